/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = scope_capture_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/sample_stream_if.sv */
// ========================================
// Valid/ready stream link with a generic payload.
// A beat moves on a clock edge with valid and ready high.
// ========================================
interface sample_stream_if #(
    parameter type payload_t = logic [31:0]
);

    logic     valid;
    logic     ready;
    payload_t payload;
    // Set on the first beat of each destination block
    logic     first;

    // Once valid is raised the source keeps valid, payload and first
    // unchanged until the beat is taken
    modport source (
        output valid,
        output payload,
        output first,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        input  first,
        output ready
    );

endinterface

/* common/scope_consts.svh */
// ========================================
// Burst shape and timing constants of the sample source.
// SCOPE_SAMPLE_GAP and SCOPE_BACKOFF must both be at least 1.
// Destinations must fit in the 8-bit destination field.
// ========================================
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// Destination channels visited in each burst
`define SCOPE_N_CHANNELS 3
// Destination number of the first channel
`define SCOPE_DEST_START 1
// Idle cycles after each non-final sample command
`define SCOPE_SAMPLE_GAP 2
// Cycles waited after dma_done before a new burst may start
`define SCOPE_BACKOFF 16

`endif

/* common/scope_control_pkg.sv */
// ========================================
// Sequencer commands, pattern selection and FSM states.
// Depends on scope_stream_pkg for the destination type.
// ========================================
package scope_control_pkg;
    import scope_stream_pkg::*;

    // Sample pattern written into the data word
    typedef enum logic {
        pattern_ramp   = 1'b0,
        pattern_tagged = 1'b1
    } pattern_mode_t;

    // One sample request from the sequencer
    typedef struct packed {
        logic [15:0] index;
        dest_t       dest;
        logic        last;
    } sample_cmd_t;

    typedef enum logic [2:0] {
        idle, issue, gap, wait_dma, backoff
    } seq_state_t;

endpackage

/* common/scope_stream_pkg.sv */
// ========================================
// Types carried on the output sample stream.
// The beat layout is shared with the DMA side.
// ========================================
package scope_stream_pkg;

    // One acquisition sample as seen by the DMA
    typedef logic [31:0] sample_word_t;

    // Destination channel number, used by the DMA to route the beat
    typedef logic [7:0] dest_t;

    // Output beat
    // last marks the final sample of the final channel in a burst
    typedef struct packed {
        sample_word_t data;
        dest_t        dest;
        logic         last;
    } sample_beat_t;

endpackage

/* data_gen/pattern_source.sv */
// ========================================
// Turns sample commands into output beats.
// mode is taken when a command is accepted.
// ========================================
module pattern_source
    import scope_stream_pkg::*;
    import scope_control_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  pattern_mode_t   mode,
    sample_stream_if.sink   cmd,
    sample_stream_if.source beat
);

    logic         beat_valid;
    sample_beat_t beat_reg;
    logic         first_reg;

    function automatic sample_word_t make_word(
        input pattern_mode_t sel,
        input logic [15:0]   index,
        input dest_t         dest
    );
        sample_word_t word;
        if (sel == pattern_tagged) begin
            // Channel tag in the top byte, index in the low half
            word = {dest, 8'h00, index};
        end else begin
            word = {16'h0000, index};
        end
        return word;
    endfunction

    // Accept a new command whenever the output register is free or draining
    assign cmd.ready = !beat_valid || beat.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            beat_valid <= 1'b0;
        end else if (cmd.ready) begin
            beat_valid <= cmd.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.valid && cmd.ready) begin
            beat_reg.data <= make_word(mode, cmd.payload.index, cmd.payload.dest);
            beat_reg.dest <= cmd.payload.dest;
            beat_reg.last <= cmd.payload.last;
            first_reg <= cmd.first;
        end
    end

    assign beat.valid = beat_valid;
    assign beat.payload = beat_reg;
    assign beat.first = first_reg;

endmodule

/* data_gen/scope_sequencer.sv */
// ========================================
// Burst sequencer of the synthetic sample source.
// packet_length is captured at burst start and must be nonzero.
// Commands wait in issue under back-pressure.
// ========================================
`include "scope_consts.svh"

module scope_sequencer
    import scope_stream_pkg::*;
    import scope_control_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   trigger,
    input  logic                   dma_done,
    input  logic [15:0]            packet_length,
    sample_stream_if.source        cmd,
    output logic                   busy
);

    localparam dest_t dest_first = dest_t'(`SCOPE_DEST_START);
    localparam dest_t dest_final = dest_t'(`SCOPE_DEST_START + `SCOPE_N_CHANNELS - 1);
    localparam logic [15:0] gap_end = 16'(`SCOPE_SAMPLE_GAP - 1);
    localparam logic [15:0] backoff_end = 16'(`SCOPE_BACKOFF - 1);

    seq_state_t  state;
    logic        trigger_prev;
    logic [15:0] index;
    dest_t       dest;
    logic [15:0] length_reg;
    logic [15:0] delay_count;

    logic start;
    logic block_end;
    logic burst_end;
    logic cmd_taken;

    // Level enable or a fresh rising edge of trigger
    assign start = enable || (trigger && !trigger_prev);

    assign block_end = (index == length_reg - 16'd1);
    assign burst_end = block_end && (dest == dest_final);
    assign cmd_taken = cmd.valid && cmd.ready;

    // The command comes straight from registers, so it stays put while stalled
    assign cmd.valid = (state == issue);
    assign cmd.first = (index == 16'd0);
    assign cmd.payload = '{index: index, dest: dest, last: burst_end};

    assign busy = (state != idle);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            trigger_prev <= 1'b0;
            index <= 16'd0;
            dest <= dest_first;
            length_reg <= 16'd0;
            delay_count <= 16'd0;
        end else begin
            trigger_prev <= trigger;
            case (state)
                idle: begin
                    index <= 16'd0;
                    dest <= dest_first;
                    delay_count <= 16'd0;
                    if (start) begin
                        length_reg <= packet_length;
                        state <= issue;
                    end
                end
                issue: begin
                    if (cmd_taken) begin
                        delay_count <= 16'd0;
                        if (burst_end) begin
                            state <= wait_dma;
                        end else begin
                            state <= gap;
                            // Step to the next channel once its block is done
                            if (block_end) begin
                                index <= 16'd0;
                                dest <= dest + 8'd1;
                            end else begin
                                index <= index + 16'd1;
                            end
                        end
                    end
                end
                gap: begin
                    if (delay_count == gap_end) begin
                        delay_count <= 16'd0;
                        state <= issue;
                    end else begin
                        delay_count <= delay_count + 16'd1;
                    end
                end
                wait_dma: begin
                    // Counter is already cleared on the way in
                    if (dma_done) begin
                        state <= backoff;
                    end
                end
                backoff: begin
                    if (delay_count == backoff_end) begin
                        state <= idle;
                    end else begin
                        delay_count <= delay_count + 16'd1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* design/scope_capture_top.sv */
// ========================================
// Synthetic capture source toward a DMA engine.
// Output follows valid/ready, out_first marks index 0.
// ========================================
module scope_capture_top
    import scope_stream_pkg::*;
    import scope_control_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          enable,
    input  logic          trigger,
    input  logic          dma_done,
    input  pattern_mode_t mode,
    input  logic [15:0]   packet_length,
    input  logic          out_ready,
    output logic          out_valid,
    output sample_word_t  out_data,
    output dest_t         out_dest,
    output logic          out_last,
    output logic          out_first,
    output logic          busy
);

    sample_stream_if #(.payload_t(sample_cmd_t))  cmd_in ();
    sample_stream_if #(.payload_t(sample_cmd_t))  cmd_out ();
    sample_stream_if #(.payload_t(sample_beat_t)) beat_in ();
    sample_stream_if #(.payload_t(sample_beat_t)) beat_out ();

    scope_sequencer sequencer_inst (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .dma_done      (dma_done),
        .packet_length (packet_length),
        .cmd           (cmd_in.source),
        .busy          (busy)
    );

    // Keeps the pattern stage ready path away from the sequencer
    stream_skid_buffer #(.payload_t(sample_cmd_t)) cmd_buffer_inst (
        .clock      (clock),
        .reset      (reset),
        .upstream   (cmd_in.sink),
        .downstream (cmd_out.source)
    );

    pattern_source pattern_inst (
        .clock (clock),
        .reset (reset),
        .mode  (mode),
        .cmd   (cmd_out.sink),
        .beat  (beat_in.source)
    );

    stream_skid_buffer #(.payload_t(sample_beat_t)) beat_buffer_inst (
        .clock      (clock),
        .reset      (reset),
        .upstream   (beat_in.sink),
        .downstream (beat_out.source)
    );

    // DMA side of the output link
    assign beat_out.ready = out_ready;
    assign out_valid = beat_out.valid;
    assign out_data = beat_out.payload.data;
    assign out_dest = beat_out.payload.dest;
    assign out_last = beat_out.payload.last;
    assign out_first = beat_out.first;

endmodule

/* design/stream_skid_buffer.sv */
// ========================================
// Two-entry skid buffer for any stream payload.
// upstream.ready comes only from the fill state.
// ========================================
module stream_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic            clock,
    input  logic            reset,
    sample_stream_if.sink   upstream,
    sample_stream_if.source downstream
);

    // Main entry drives the output, skid entry catches a beat during a stall
    logic     main_valid;
    payload_t main_payload;
    logic     main_first;
    logic     skid_valid;
    payload_t skid_payload;
    logic     skid_first;

    logic main_load;
    logic skid_load;

    // Main entry may change only when it is empty or being taken
    assign main_load = downstream.ready || !main_valid;
    assign skid_load = !main_load && upstream.valid && upstream.ready;

    assign upstream.ready = !skid_valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid || upstream.valid;
            skid_valid <= 1'b0;
        end else if (skid_load) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (main_load) begin
            // The older beat in the skid entry goes out first
            main_payload <= skid_valid ? skid_payload : upstream.payload;
            main_first <= skid_valid ? skid_first : upstream.first;
        end
        if (skid_load) begin
            skid_payload <= upstream.payload;
            skid_first <= upstream.first;
        end
    end

    assign downstream.valid = main_valid;
    assign downstream.payload = main_payload;
    assign downstream.first = main_first;

endmodule

/* dv/scope_capture_properties.sv */
// ========================================
// Bound checker with a reference model of the output stream.
// Assumes packet_length and mode only change while idle.
// ========================================
`include "scope_consts.svh"

module scope_capture_properties
    import scope_stream_pkg::*;
    import scope_control_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input logic          enable,
    input logic          trigger,
    input logic          dma_done,
    input pattern_mode_t mode,
    input logic [15:0]   packet_length,
    input logic          out_ready,
    input logic          out_valid,
    input sample_word_t  out_data,
    input dest_t         out_dest,
    input logic          out_last,
    input logic          out_first,
    input logic          busy
);

    localparam dest_t dest_first = dest_t'(`SCOPE_DEST_START);
    localparam dest_t dest_final = dest_t'(`SCOPE_DEST_START + `SCOPE_N_CHANNELS - 1);

    int fail_count = 0;

    logic [15:0]  exp_index;
    dest_t        exp_dest;
    logic         exp_last;
    sample_word_t exp_data;
    logic         burst_done;
    logic         started;
    logic         trig_prev;
    logic [15:0]  backoff_left;
    logic         check_drop;
    logic         start_cond;

    assign exp_last = (exp_index == packet_length - 16'd1) && (exp_dest == dest_final);
    assign exp_data = (mode == pattern_tagged) ? {exp_dest, 8'h00, exp_index}
                                               : {16'h0000, exp_index};
    assign start_cond = enable || (trigger && !trig_prev);

    always_ff @(posedge clock) begin
        if (!reset) begin
            exp_index <= 16'd0;
            exp_dest <= dest_first;
            burst_done <= 1'b0;
            started <= 1'b0;
            trig_prev <= 1'b0;
            backoff_left <= 16'd0;
            check_drop <= 1'b0;
        end else begin
            trig_prev <= trigger;
            if (start_cond) begin
                started <= 1'b1;
            end
            // Step the expected position on every accepted beat
            if (out_valid && out_ready) begin
                if (exp_last) begin
                    exp_index <= 16'd0;
                    exp_dest <= dest_first;
                    burst_done <= 1'b1;
                end else if (exp_index == packet_length - 16'd1) begin
                    exp_index <= 16'd0;
                    exp_dest <= exp_dest + 8'd1;
                end else begin
                    exp_index <= exp_index + 16'd1;
                end
            end
            if (burst_done && dma_done) begin
                burst_done <= 1'b0;
                backoff_left <= 16'(`SCOPE_BACKOFF);
                check_drop <= 1'b0;
            end else if (backoff_left != 16'd0) begin
                backoff_left <= backoff_left - 16'd1;
                check_drop <= (backoff_left == 16'd1);
            end else begin
                check_drop <= 1'b0;
            end
        end
    end

    reset_clears: assert property (@(posedge clock) !reset |=> !busy && !out_valid)
        else begin
            fail_count++;
            $error("%0t busy or out_valid high after reset", $time);
        end

    idle_until_start: assert property (@(posedge clock) disable iff (!reset)
        !started |-> !busy && !out_valid)
        else begin
            fail_count++;
            $error("%0t activity before any start", $time);
        end

    start_when_asked: assert property (@(posedge clock) disable iff (!reset)
        !busy && start_cond |=> busy)
        else begin
            fail_count++;
            $error("%0t start condition ignored", $time);
        end

    no_spurious_start: assert property (@(posedge clock) disable iff (!reset)
        !busy && !start_cond |=> !busy)
        else begin
            fail_count++;
            $error("%0t burst started without a start", $time);
        end

    data_matches: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> out_data == exp_data && out_dest == exp_dest)
        else begin
            fail_count++;
            $error("%0t out_data or out_dest wrong", $time);
        end

    framing_matches: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> out_first == (exp_index == 16'd0) && out_last == exp_last)
        else begin
            fail_count++;
            $error("%0t out_first or out_last wrong", $time);
        end

    stall_holds: assert property (@(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest)
            && $stable(out_last) && $stable(out_first))
        else begin
            fail_count++;
            $error("%0t stalled beat changed", $time);
        end

    quiet_after_last: assert property (@(posedge clock) disable iff (!reset)
        burst_done |-> busy && !out_valid)
        else begin
            fail_count++;
            $error("%0t beat or idle before dma_done", $time);
        end

    busy_in_backoff: assert property (@(posedge clock) disable iff (!reset)
        backoff_left != 16'd0 |-> busy)
        else begin
            fail_count++;
            $error("%0t busy fell during backoff", $time);
        end

    idle_after_backoff: assert property (@(posedge clock) disable iff (!reset)
        check_drop |-> !busy)
        else begin
            fail_count++;
            $error("%0t busy still high after backoff", $time);
        end

endmodule

bind scope_capture_top scope_capture_properties properties_inst (
    .clock         (clock),
    .reset         (reset),
    .enable        (enable),
    .trigger       (trigger),
    .dma_done      (dma_done),
    .mode          (mode),
    .packet_length (packet_length),
    .out_ready     (out_ready),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_dest      (out_dest),
    .out_last      (out_last),
    .out_first     (out_first),
    .busy          (busy)
);

/* dv/scope_capture_tb.sv */
// ========================================
// Testbench for the synthetic capture source.
// Checking is done by the bound property module.
// ========================================
`include "scope_consts.svh"

module scope_capture_tb
    import scope_stream_pkg::*;
    import scope_control_pkg::*;
;

    localparam int sink_limit = 4000;
    localparam int busy_limit = `SCOPE_BACKOFF + 40;

    logic          clock;
    logic          reset;
    logic          enable;
    logic          trigger;
    logic          dma_done;
    pattern_mode_t mode;
    logic [15:0]   packet_length;
    logic          out_ready;
    logic          out_valid;
    sample_word_t  out_data;
    dest_t         out_dest;
    logic          out_last;
    logic          out_first;
    logic          busy;

    integer seed = 48;
    int tests_run = 0;
    int tests_failed = 0;
    int timeouts = 0;
    int fails_before;
    int timeouts_before;

    scope_capture_top scope_capture_top_inst (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .trigger       (trigger),
        .dma_done      (dma_done),
        .mode          (mode),
        .packet_length (packet_length),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .out_last      (out_last),
        .out_first     (out_first),
        .busy          (busy)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic int assertion_failures();
        return scope_capture_top_inst.properties_inst.fail_count;
    endfunction

    task automatic step(input int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (busy !== level) begin
            timeouts++;
            $display("timeout: busy did not become %0b within %0d cycles at time %0t",
                     level, limit, $time);
        end
    endtask

    // Acts as the DMA sink until the beat marked last is taken
    task automatic sink_until_last(input bit stalls);
        int cycles;
        int r;
        bit done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < sink_limit) begin
            @(negedge clock);
            cycles++;
            r = $random(seed);
            out_ready = stalls ? (r[1:0] != 2'b00) : 1'b1;
            if (out_valid && out_ready && out_last) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            timeouts++;
            $display("timeout: no last beat was taken within %0d cycles at time %0t",
                     sink_limit, $time);
        end
    endtask

    // Waits a while after last, acknowledges the DMA and waits for idle
    task automatic close_burst(input int hold_cycles, input bit drop_enable);
        step(1);
        out_ready = 1'b1;
        step(hold_cycles);
        dma_done = 1'b1;
        if (drop_enable) begin
            enable = 1'b0;
        end
        step(1);
        dma_done = 1'b0;
        wait_busy(1'b0, busy_limit);
    endtask

    task automatic pulse_trigger();
        trigger = 1'b1;
        step(1);
        trigger = 1'b0;
    endtask

    task automatic begin_test();
        fails_before = assertion_failures();
        timeouts_before = timeouts;
    endtask

    task automatic end_test(input string name);
        int new_fails;
        new_fails = assertion_failures() - fails_before;
        tests_run++;
        if (new_fails == 0 && timeouts == timeouts_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d assertion failures and %0d timeouts",
                     tests_run, name, new_fails, timeouts - timeouts_before);
        end
    endtask

    task automatic run_triggered_burst(input bit stalls, input int hold_cycles);
        pulse_trigger();
        wait_busy(1'b1, 10);
        sink_until_last(stalls);
        close_burst(hold_cycles, 1'b0);
    endtask

    initial begin
        reset = 1'b0;
        enable = 1'b0;
        trigger = 1'b0;
        dma_done = 1'b0;
        mode = pattern_ramp;
        packet_length = 16'd4;
        out_ready = 1'b1;

        begin_test();
        step(4);
        reset = 1'b1;
        step(10);
        end_test("reset and idle");

        begin_test();
        packet_length = 16'd5;
        run_triggered_burst(1'b0, 4);
        end_test("ramp burst");

        begin_test();
        mode = pattern_tagged;
        packet_length = 16'd4;
        run_triggered_burst(1'b0, 4);
        end_test("tagged burst");

        begin_test();
        mode = pattern_ramp;
        packet_length = 16'd6;
        run_triggered_burst(1'b1, 4);
        mode = pattern_tagged;
        run_triggered_burst(1'b1, 3);
        end_test("random back-pressure");

        begin_test();
        mode = pattern_ramp;
        packet_length = 16'd2;
        run_triggered_burst(1'b0, 20);
        end_test("end of burst");

        begin_test();
        packet_length = 16'd3;
        // A held trigger must give one burst only
        trigger = 1'b1;
        wait_busy(1'b1, 10);
        sink_until_last(1'b0);
        close_burst(4, 1'b0);
        step(12);
        trigger = 1'b0;
        step(1);
        trigger = 1'b1;
        wait_busy(1'b1, 10);
        sink_until_last(1'b0);
        close_burst(2, 1'b0);
        trigger = 1'b0;
        // Level enable restarts right after each backoff
        enable = 1'b1;
        wait_busy(1'b1, 10);
        sink_until_last(1'b0);
        close_burst(2, 1'b0);
        sink_until_last(1'b1);
        close_burst(2, 1'b1);
        step(6);
        end_test("start conditions");

        $display("tests run %0d, failed %0d, assertion failures %0d, timeouts %0d",
                 tests_run, tests_failed, assertion_failures(), timeouts);
        if (tests_failed == 0 && timeouts == 0 && assertion_failures() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/scope_stream_pkg.sv
common/scope_control_pkg.sv
common/sample_stream_if.sv
design/stream_skid_buffer.sv
data_gen/scope_sequencer.sv
data_gen/pattern_source.sv
design/scope_capture_top.sv
dv/scope_capture_properties.sv
dv/scope_capture_tb.sv
